// ==== debugTop.f ====
logic/debugPkg.sv
logic/serialReceiver.sv
logic/messageQueue.sv
logic/commandHandler.sv
logic/serialTransmitter.sv
logic/debugTop.sv
dv/clockGen.sv
dv/debugTop_assert.sv
dv/debugTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := debugTb
FILELIST  := debugTop.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== dv/debugTb.sv ====
`timescale 1ns/1ps

module debugTb import debugPkg::*; ();

    localparam int ClockPeriod   = 100;
    localparam int ResetCycles   = 16;
    localparam int Seed          = 42;
    localparam int TimeoutMargin = 2000;
    localparam int GapBytes      = 5;
    localparam int RandomMsgs    = 50;

    // Reply as seen on debugDo, with led sampled when its last bit arrives
    typedef struct packed {
        replyT               reply;
        logic [LedWidth-1:0] led;
    } replyRecordT;

    // One byte period of stimulus
    typedef struct packed {
        logic    cs;
        msgByteT data;
    } linkSlotT;

    logic                clk;
    logic                reset;
    logic                debugCs;
    logic                debugDi;
    logic                debugDo;
    logic [LedWidth-1:0] led;

    linkSlotT            stream[$];
    replyRecordT         expQ[$];
    replyRecordT         gotQ[$];
    replyRecordT         rxRec;
    logic [LedWidth-1:0] modelLed;
    logic [31:0]         lcgState;
    msgByteT             rxShift;
    int                  rxBitCnt;
    int                  rxPhase;
    int                  cycleCount = 0;
    int                  timeoutLimit = TimeoutMargin;
    int                  replyCount = 0;

    clockGen #(.PeriodNs(ClockPeriod), .ResetCycles(ResetCycles)) clockGen_inst (
        .clk   (clk),
        .reset (reset)
    );

    debugTop debugTop_inst (
        .clk     (clk),
        .reset   (reset),
        .debugCs (debugCs),
        .debugDi (debugDi),
        .debugDo (debugDo),
        .led     (led)
    );

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(string name, msgByteT got, msgByteT expected);
        if (got !== expected) begin
            failRun($sformatf("MISMATCH %s got 0x%02h expected 0x%02h", name, got, expected));
        end
    endtask

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    // ==============================
    // Reference model
    // ==============================
    function automatic replyRecordT expectedReply(msgByteT msgType, msgByteT firstByte,
                                                  logic [LedWidth-1:0] curLed);
        replyRecordT rec;
        rec.led              = curLed;
        rec.reply.msgType    = msgType;
        rec.reply.payloadLen = 8'h00;
        rec.reply.payload    = 8'h00;
        if (msgType == MsgTypeSetLed) begin
            rec.led[0]           = firstByte[0];
            rec.reply.payloadLen = 8'h01;
            rec.reply.payload    = msgByteT'(rec.led);
        end
        return rec;
    endfunction

    // ==============================
    // Stimulus
    // ==============================
    task automatic queueSlot(logic cs, msgByteT data);
        linkSlotT slot;
        slot.cs   = cs;
        slot.data = data;
        stream.push_back(slot);
    endtask

    task automatic fillerBytes(logic cs, int count);
        for (int i = 0; i < count; i++) begin
            queueSlot(cs, 8'h00);
        end
    endtask

    task automatic requestMessage(msgByteT msgType, msgByteT payloadLen, msgByteT firstByte);
        replyRecordT rec;
        msgByteT     p0;
        queueSlot(1'b1, msgType);
        queueSlot(1'b1, payloadLen);
        for (int i = 0; i < int'(payloadLen); i++) begin
            queueSlot(1'b1, (i == 0) ? firstByte : msgByteT'(nextRand()));
        end
        // Missing payload bytes read as zero
        p0       = (payloadLen != 8'h00) ? firstByte : 8'h00;
        rec      = expectedReply(msgType, p0, modelLed);
        modelLed = rec.led;
        expQ.push_back(rec);
        fillerBytes(1'b1, GapBytes);
    endtask

    task automatic buildStream();
        msgByteT randType;
        msgByteT randLen;
        fillerBytes(1'b0, 2);
        fillerBytes(1'b1, 3);
        // Set, clear and set led bit 0
        requestMessage(MsgTypeSetLed, 8'd1, 8'h01);
        requestMessage(MsgTypeSetLed, 8'd1, 8'h00);
        requestMessage(MsgTypeSetLed, 8'd1, 8'h03);
        // Unknown types leave led alone
        requestMessage(8'h5a, 8'd0, 8'h00);
        requestMessage(8'h7e, 8'd2, 8'h00);
        fillerBytes(1'b1, 12);
        // Oversized SetLed, then a short message right behind it
        requestMessage(MsgTypeSetLed, 8'd7, 8'h00);
        requestMessage(8'h33, 8'd0, 8'h00);
        // Chip select drops inside a SetLed that would clear led
        requestMessage(MsgTypeSetLed, 8'd1, 8'h01);
        queueSlot(1'b1, MsgTypeSetLed);
        queueSlot(1'b1, 8'd3);
        queueSlot(1'b1, 8'h00);
        fillerBytes(1'b0, 3);
        fillerBytes(1'b1, 2);
        requestMessage(8'h44, 8'd0, 8'h00);
        requestMessage(MsgTypeSetLed, 8'd1, 8'h00);
        for (int i = 0; i < RandomMsgs; i++) begin
            randLen = msgByteT'(nextRand() % 8);
            if (nextRand() % 3 == 0) begin
                randType = MsgTypeSetLed;
            end else begin
                randType = msgByteT'(nextRand() % 255 + 1);
            end
            requestMessage(randType, randLen, msgByteT'(nextRand()));
        end
    endtask

    task automatic driveSlot(linkSlotT slot);
        for (int i = ByteWidth - 1; i >= 0; i--) begin
            debugCs = slot.cs;
            debugDi = slot.data[i];
            @(posedge clk);
            #1;
        end
    endtask

    // ==============================
    // debugDo capture
    // ==============================
    task automatic collectByte(msgByteT data);
        logic done;
        done = 1'b0;
        case (rxPhase)
            0: begin
                // Zero bytes are idle filler
                if (data != 8'h00) begin
                    rxRec.reply.msgType = data;
                    rxPhase             = 1;
                end
            end
            1: begin
                rxRec.reply.payloadLen = data;
                rxRec.reply.payload    = 8'h00;
                if (data == 8'h00) begin
                    done = 1'b1;
                end else begin
                    rxPhase = 2;
                end
            end
            default: begin
                rxRec.reply.payload = data;
                done                = 1'b1;
            end
        endcase
        if (done) begin
            rxRec.led = led;
            gotQ.push_back(rxRec);
            rxPhase = 0;
        end
    endtask

    // Bits taken mid-cycle where debugDo and led have settled
    always @(negedge clk) begin
        if (reset || !debugCs) begin
            rxBitCnt = 0;
            rxPhase  = 0;
        end else begin
            rxShift  = {rxShift[ByteWidth-2:0], debugDo};
            rxBitCnt = rxBitCnt + 1;
            if (rxBitCnt == ByteWidth) begin
                rxBitCnt = 0;
                collectByte(rxShift);
            end
        end
    end

    initial begin
        replyRecordT gotRec;
        replyRecordT expRec;
        forever begin
            @(posedge clk);
            while (gotQ.size() != 0) begin
                gotRec = gotQ.pop_front();
                if (expQ.size() == 0) begin
                    failRun($sformatf("Unexpected reply of type 0x%02h on debugDo",
                                      gotRec.reply.msgType));
                end else begin
                    expRec = expQ.pop_front();
                    checkValue("reply.msgType", gotRec.reply.msgType, expRec.reply.msgType);
                    checkValue("reply.payloadLen", gotRec.reply.payloadLen,
                               expRec.reply.payloadLen);
                    checkValue("reply.payload", gotRec.reply.payload, expRec.reply.payload);
                    checkValue("led", msgByteT'(gotRec.led), msgByteT'(expRec.led));
                    replyCount++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            failRun($sformatf("Timeout after %0d cycles with %0d replies still expected",
                              cycleCount, expQ.size()));
        end
    end

    initial begin
        debugCs  = 1'b0;
        debugDi  = 1'b0;
        lcgState = 32'(Seed);
        modelLed = '0;
        buildStream();
        // Twice the stimulus length plus room for the last replies
        timeoutLimit = 2 * ByteWidth * stream.size() + TimeoutMargin;
        @(negedge reset);
        @(posedge clk);
        #1;
        foreach (stream[i]) begin
            driveSlot(stream[i]);
        end
        debugCs = 1'b1;
        debugDi = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        // Quiet tail where any further reply byte is a stray
        repeat (4 * ByteWidth) @(posedge clk);
        if (rxPhase != 0) begin
            failRun("A partial reply was left on debugDo after the last expected reply");
        end else begin
            $display("Checked %0d replies", replyCount);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== dv/debugTop_assert.sv ====
`timescale 1ns/1ps

module debugTop_assert import debugPkg::*; (
    input logic                clk,
    input logic                reset,
    input logic                replyValid,
    input logic                txBusy,
    input logic                qPop,
    input logic                qValid,
    input logic [LedWidth-1:0] led,
    input logic                debugDo
);

    // Handler waits for the transmitter before issuing a reply
    replyWhileIdle: assert property (@(posedge clk) disable iff (reset) replyValid |-> !txBusy)
        else $error("replyValid fired while txBusy was high");

    // Head of the queue is only dropped when there is one
    popWithData: assert property (@(posedge clk) disable iff (reset) qPop |-> qValid)
        else $error("qPop fired while the message queue was empty");

    // Outputs come out of reset cleared
    resetOutputs: assert property (@(posedge clk) reset |=> (led == '0 && !debugDo))
        else $error("led or debugDo not cleared after reset");

endmodule

bind debugTop debugTop_assert debugTop_assert_inst (
    .clk        (clk),
    .reset      (reset),
    .replyValid (replyValid),
    .txBusy     (txBusy),
    .qPop       (qPop),
    .qValid     (qValid),
    .led        (led),
    .debugDo    (debugDo)
);

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int PeriodNs    = 100,
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Release lines up with the stimulus, just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== logic/debugTop.sv ====
`timescale 1ns/1ps

module debugTop import debugPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                debugCs,
    input  logic                debugDi,
    output logic                debugDo,
    output logic [LedWidth-1:0] led
);

    debugMsgU rxMsg;
    logic     rxValid;
    debugMsgU qMsg;
    logic     qValid;
    logic     qPop;
    replyT    reply;
    logic     replyValid;
    logic     txBusy;

    // ==============================
    // Input side
    // ==============================
    serialReceiver serialReceiver_inst (
        .clk     (clk),
        .reset   (reset),
        .debugCs (debugCs),
        .debugDi (debugDi),
        .rxMsg   (rxMsg),
        .rxValid (rxValid)
    );

    messageQueue messageQueue_inst (
        .clk     (clk),
        .reset   (reset),
        .rxMsg   (rxMsg),
        .rxValid (rxValid),
        .qMsg    (qMsg),
        .qValid  (qValid),
        .qPop    (qPop)
    );

    // Command processing
    commandHandler commandHandler_inst (
        .clk        (clk),
        .reset      (reset),
        .qMsg       (qMsg),
        .qValid     (qValid),
        .qPop       (qPop),
        .reply      (reply),
        .replyValid (replyValid),
        .txBusy     (txBusy),
        .led        (led)
    );

    // ==============================
    // Output side
    // ==============================
    serialTransmitter serialTransmitter_inst (
        .clk        (clk),
        .reset      (reset),
        .debugCs    (debugCs),
        .reply      (reply),
        .replyValid (replyValid),
        .txBusy     (txBusy),
        .debugDo    (debugDo)
    );

endmodule

// ==== logic/serialTransmitter.sv ====
`timescale 1ns/1ps

module serialTransmitter import debugPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  debugCs,
    input  replyT reply,
    input  logic  replyValid,
    output logic  txBusy,
    output logic  debugDo
);

    logic [BitCntWidth-1:0] bitCnt;
    msgByteT                shiftReg;
    replyT                  pendReply;
    logic [1:0]             byteIdx;
    msgByteT                nextByte;
    logic                   lastByte;
    logic                   byteEnd;

    // MSB first
    assign debugDo = shiftReg[ByteWidth-1];

    assign byteEnd = (bitCnt == BitCntWidth'(ByteWidth - 1));

    // Reply bytes in wire order
    always_comb begin
        case (byteIdx)
            2'd0:    nextByte = pendReply.msgType;
            2'd1:    nextByte = pendReply.payloadLen;
            default: nextByte = pendReply.payload;
        endcase
    end

    // Empty replies end after the length byte
    assign lastByte = (byteIdx == 2'd2) ||
                      (byteIdx == 2'd1 && pendReply.payloadLen == '0);

    // Reply storage
    always_ff @(posedge clk) begin
        if (replyValid) begin
            pendReply <= reply;
        end
    end

    // ==============================
    // Shifter
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            bitCnt   <= '0;
            shiftReg <= '0;
            byteIdx  <= '0;
            txBusy   <= 1'b0;
        end else begin
            if (replyValid) begin
                txBusy <= 1'b1;
            end

            if (!debugCs) begin
                // Framing restarts, a pending reply is resent from its type byte
                bitCnt   <= '0;
                shiftReg <= '0;
                byteIdx  <= '0;
            end else begin
                bitCnt <= bitCnt + 1'b1;
                if (byteEnd) begin
                    if (txBusy) begin
                        shiftReg <= nextByte;
                        if (lastByte) begin
                            byteIdx <= '0;
                            txBusy  <= 1'b0;
                        end else begin
                            byteIdx <= byteIdx + 1'b1;
                        end
                    end else begin
                        // Nothing to send, so idle filler
                        shiftReg <= '0;
                    end
                end else begin
                    shiftReg <= shiftReg << 1;
                end
            end
        end
    end

endmodule

// ==== logic/commandHandler.sv ====
`timescale 1ns/1ps

module commandHandler import debugPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  debugMsgU            qMsg,
    input  logic                qValid,
    output logic                qPop,
    output replyT               reply,
    output logic                replyValid,
    input  logic                txBusy,
    output logic [LedWidth-1:0] led
);

    typedef enum logic {
        Fetch,
        Respond
    } handlerStateT;

    handlerStateT        state;
    msgFieldsT           curMsg;
    logic [LedWidth-1:0] nextLed;
    replyT               nextReply;

    // ==============================
    // Command decode
    // ==============================
    always_comb begin
        nextLed              = led;
        nextReply.msgType    = curMsg.msgType;
        nextReply.payloadLen = '0;
        nextReply.payload    = '0;
        if (curMsg.msgType == MsgTypeSetLed) begin
            nextLed[0]           = curMsg.payload[0][0];
            nextReply.payloadLen = 8'd1;
            // Echo the whole led value back
            nextReply.payload    = {{(ByteWidth - LedWidth){1'b0}}, nextLed};
        end
        // Other types are acknowledged with an empty reply
    end

    // Head of the queue and the outgoing reply
    always_ff @(posedge clk) begin
        if (state == Fetch && qValid) begin
            curMsg <= qMsg.fields;
        end
        if (state == Respond && !txBusy) begin
            reply <= nextReply;
        end
    end

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= Fetch;
            qPop       <= 1'b0;
            replyValid <= 1'b0;
            led        <= '0;
        end else begin
            qPop       <= 1'b0;
            replyValid <= 1'b0;
            case (state)
                Fetch: begin
                    if (qValid) begin
                        qPop  <= 1'b1;
                        state <= Respond;
                    end
                end

                Respond: begin
                    // Hold here while the transmitter is still sending
                    if (!txBusy) begin
                        replyValid <= 1'b1;
                        led        <= nextLed;
                        state      <= Fetch;
                    end
                end

                default: state <= Fetch;
            endcase
        end
    end

endmodule

// ==== logic/messageQueue.sv ====
`timescale 1ns/1ps

module messageQueue import debugPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  debugMsgU rxMsg,
    input  logic     rxValid,
    output debugMsgU qMsg,
    output logic     qValid,
    input  logic     qPop
);

    debugMsgU                     mem [MsgQueueDepth];
    logic [MsgQueueAddrWidth-1:0] wrPtr;
    logic [MsgQueueAddrWidth-1:0] rdPtr;
    logic [MsgQueueAddrWidth:0]   count;
    logic                         doPush;
    logic                         doPop;

    // A message arriving while full is dropped
    assign doPush = rxValid && (count != MsgQueueDepth);
    assign doPop  = qPop && (count != '0);

    assign qMsg   = mem[rdPtr];
    assign qValid = (count != '0);

    // Storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= rxMsg;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/serialReceiver.sv ====
`timescale 1ns/1ps

module serialReceiver import debugPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     debugCs,
    input  logic     debugDi,
    output debugMsgU rxMsg,
    output logic     rxValid
);

    typedef enum logic [1:0] {
        WaitType,
        TakeLen,
        TakePayload
    } rxStateT;

    rxStateT                state;
    logic [BitCntWidth-1:0] bitCnt;
    logic [ByteWidth-2:0]   shiftReg;
    msgByteT                payloadCnt;
    msgByteT                curByte;
    logic                   byteDone;
    logic [2:0]             storeIdx;

    // Byte completes with the bit sampled on this edge
    assign curByte  = {shiftReg, debugDi};
    assign byteDone = (bitCnt == BitCntWidth'(ByteWidth - 1));

    // Byte slot in the message for the current payload byte
    assign storeIdx = payloadCnt[2:0] + 3'(MsgHeaderLen);

    // ==============================
    // Framing
    // ==============================
    always_ff @(posedge clk) begin
        if (reset || !debugCs) begin
            // Dropping chip select loses any partial message
            state      <= WaitType;
            bitCnt     <= '0;
            shiftReg   <= '0;
            payloadCnt <= '0;
            rxValid    <= 1'b0;
        end else begin
            rxValid  <= 1'b0;
            bitCnt   <= bitCnt + 1'b1;
            shiftReg <= curByte[ByteWidth-2:0];

            if (byteDone) begin
                case (state)
                    WaitType: begin
                        // Filler bytes keep us here, so a message may start anywhere
                        if (curByte != MsgTypeNop) begin
                            rxMsg.bytes[0] <= curByte;
                            state          <= TakeLen;
                        end
                    end

                    TakeLen: begin
                        rxMsg.bytes[1] <= curByte;
                        rxMsg.bytes[MsgMaxLen-1:MsgHeaderLen] <= '0;
                        payloadCnt     <= '0;
                        if (curByte == '0) begin
                            rxValid <= 1'b1;
                            state   <= WaitType;
                        end else begin
                            state <= TakePayload;
                        end
                    end

                    TakePayload: begin
                        // Extra payload bytes are counted but not kept
                        if (payloadCnt < MsgMaxPayloadLen) begin
                            rxMsg.bytes[storeIdx] <= curByte;
                        end
                        payloadCnt <= payloadCnt + 8'd1;
                        if (payloadCnt + 8'd1 == rxMsg.fields.payloadLen) begin
                            rxValid <= 1'b1;
                            state   <= WaitType;
                        end
                    end

                    default: begin
                        state <= WaitType;
                    end
                endcase
            end
        end
    end

endmodule

// ==== logic/debugPkg.sv ====
package debugPkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int ByteWidth = 8;
    localparam int BitCntWidth = $clog2(ByteWidth);
    localparam int MsgHeaderLen = 2;
    localparam int MsgMaxPayloadLen = 5;
    localparam int MsgMaxLen = MsgHeaderLen + MsgMaxPayloadLen;
    localparam int MsgQueueDepth = 4;
    localparam int MsgQueueAddrWidth = $clog2(MsgQueueDepth);
    localparam int LedWidth = 4;

    typedef logic [ByteWidth-1:0] msgByteT;

    // ==============================
    // Message types
    // ==============================
    // Zero is idle filler on the serial line
    localparam msgByteT MsgTypeNop = 8'h00;
    localparam msgByteT MsgTypeSetLed = 8'h01;

    // ==============================
    // Message formats
    // ==============================
    // Type in the lowest byte, payload byte 0 just above the length
    typedef struct packed {
        msgByteT [MsgMaxPayloadLen-1:0] payload;
        msgByteT                        payloadLen;
        msgByteT                        msgType;
    } msgFieldsT;

    // Byte view used while framing, field view used while decoding
    typedef union packed {
        msgFieldsT                fields;
        msgByteT [MsgMaxLen-1:0] bytes;
    } debugMsgU;

    // Replies carry at most one payload byte
    typedef struct packed {
        msgByteT payload;
        msgByteT payloadLen;
        msgByteT msgType;
    } replyT;

endpackage
